/* logic/icachePkg.sv */
package icachePkg;

  //////////////////////////////////////////////////////////////////////
  // address split and cache geometry
  //////////////////////////////////////////////////////////////////////

  localparam int tagW = 6;                    // tag bits addr[15:10]
  localparam int setW = 6;                    // set index bits addr[9:4]
  localparam int offW = 3;                    // word offset bits addr[3:1]
  localparam int wordW = 16;                  // instruction word and address width

  localparam int numSets = 64;                // default set count
  localparam int blockWords = 8;              // words per block

  // cpu address as seen by the cache with bit 0 unused
  typedef struct packed {
    logic [tagW-1:0] tag;                     // compared against metaEntry.tag
    logic [setW-1:0] set;                     // picks the set in both ways
    logic [offW-1:0] off;                     // word within the block
    logic            pad;                     // ignored
  } addrFields;

  //////////////////////////////////////////////////////////////////////
  // per-set metadata, one entry per way
  //////////////////////////////////////////////////////////////////////

  // lru in bit 7 and vld in bit 6 above the tag
  typedef struct packed {
    logic            lru;                     // set when this way was used last
    logic            vld;                     // block holds real data
    logic [tagW-1:0] tag;                     // tag of the resident block
  } metaEntry;

  // miss handling states
  typedef enum logic [1:0] {
    idle,                                     // waiting for a miss
    fetch,                                    // issue one memory read
    waitAck,                                  // wait for the word to come back
    commit                                    // write the new metadata
  } fillState;

endpackage

/* logic/dataArray.sv */
`timescale 1ns/1ns

module dataArray #(
  parameter int setCount = icachePkg::numSets,
  localparam int idxW = $clog2(setCount)
) (
  input  logic                        clk,
  input  logic                        we,       // write one word this cycle
  input  logic [idxW-1:0]             setIdx,   // block select
  input  logic [icachePkg::offW-1:0]  off,      // word select for read and write
  input  logic [icachePkg::wordW-1:0] wdata,    // word from the fill path
  output logic [icachePkg::wordW-1:0] rdata     // word at setIdx/off
);

  //////////////////////////////////////////////////////////////////////
  // setCount blocks of blockWords words
  //////////////////////////////////////////////////////////////////////

  logic [icachePkg::wordW-1:0] mem [setCount][icachePkg::blockWords];

  // the fill path writes one word per memAck
  always_ff @(posedge clk) begin
    if (we) begin
      mem[setIdx][off] <= wdata;                // single word write
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  // combinational so a hit returns the word in the same cycle
  assign rdata = mem[setIdx][off];

endmodule

/* logic/metaArray.sv */
`timescale 1ns/1ns

module metaArray #(
  parameter int setCount = icachePkg::numSets,
  localparam int idxW = $clog2(setCount)
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                we,               // write wentry at setIdx
  input  logic [idxW-1:0]     setIdx,           // shared read/write index
  input  icachePkg::metaEntry wentry,           // new lru/vld/tag
  output icachePkg::metaEntry rentry            // entry at setIdx
);

  //////////////////////////////////////////////////////////////////////
  // one entry per set
  //////////////////////////////////////////////////////////////////////

  icachePkg::metaEntry mem [setCount];

  // rst clears every vld and lru bit
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < setCount; i++) begin
        mem[i] <= '0;                           // invalid and not recently used
      end
    end else if (we) begin
      mem[setIdx] <= wentry;                    // hit update or fill commit
    end
  end

  // combinational read feeds the tag compare directly
  assign rentry = mem[setIdx];

endmodule

/* logic/icacheWays.sv */
`timescale 1ns/1ns

module icacheWays #(
  parameter int setCount = icachePkg::numSets
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd,        // cpu read level
  input  logic [icachePkg::wordW-1:0] addr,      // cpu word address
  input  logic                        dataWe,    // fill word write
  input  logic                        fillWay,   // way being filled
  input  logic [icachePkg::offW-1:0]  fillOff,   // offset being filled
  input  logic [icachePkg::wordW-1:0] fillData,  // word being filled
  input  logic                        metaWe,    // fill commit strobe
  output logic [icachePkg::wordW-1:0] instr,     // word to the cpu
  output logic                        miss,      // read and no way hits
  output logic                        victimWay  // way to replace on a miss
);

  localparam int idxW = $clog2(setCount);

  icachePkg::addrFields              fields;     // decoded cpu address
  logic [idxW-1:0]                   curSet;     // set of the current access
  logic [idxW-1:0]                   metaSet;    // metadata index, read and write
  logic [icachePkg::offW-1:0]        wordOff;    // data word index
  logic [1:0][icachePkg::wordW-1:0]  wayData;    // word read from each way
  icachePkg::metaEntry [1:0]         wayMeta;    // entry read from each way
  icachePkg::metaEntry [1:0]         pendMeta;   // registered hit update
  icachePkg::metaEntry [1:0]         wentry;     // entry written to each way
  logic [idxW-1:0]                   pendSet;    // set of the registered update
  logic                              pendWe;     // hit update due this cycle
  logic [1:0]                        hitWay;     // per-way hit
  logic                              anyHit;

  // chosen way becomes most recent with the new tag, the other only loses lru
  function automatic icachePkg::metaEntry touch(
    input icachePkg::metaEntry        old,
    input logic                       sel,
    input logic [icachePkg::tagW-1:0] tag
  );
    icachePkg::metaEntry nxt;
    if (sel) begin
      nxt = '{lru: 1'b1, vld: 1'b1, tag: tag};
    end else begin
      nxt = '{lru: 1'b0, vld: old.vld, tag: old.tag};
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // address decode and array indexing
  //////////////////////////////////////////////////////////////////////

  assign fields  = addr;
  assign curSet  = addr[icachePkg::offW+1 +: idxW];  // set bits above the offset
  assign metaSet = pendWe ? pendSet : curSet;        // late hit write owns the port
  assign wordOff = dataWe ? fillOff : fields.off;    // fill word or cpu word

  for (genvar w = 0; w < 2; w++) begin : g_way
    dataArray #(
      .setCount(setCount)
    ) u_data (
      .clk   (clk),
      .we    (dataWe && (fillWay == 1'(w))),   // only the victim takes fill words
      .setIdx(curSet),                         // addr is held during the fill
      .off   (wordOff),
      .wdata (fillData),
      .rdata (wayData[w])
    );

    metaArray #(
      .setCount(setCount)
    ) u_meta (
      .clk   (clk),
      .rst   (rst),
      .we    (metaWe || pendWe),               // both ways always written together
      .setIdx(metaSet),
      .wentry(wentry[w]),
      .rentry(wayMeta[w])
    );

    // compare blocked while this way's metadata write is still in flight
    assign hitWay[w] = wayMeta[w].vld && (wayMeta[w].tag == fields.tag) && !pendWe;

    // commit goes straight in, hit updates come from the register
    assign wentry[w] = metaWe ? touch(wayMeta[w], fillWay == 1'(w), fields.tag)
                              : pendMeta[w];
  end

  //////////////////////////////////////////////////////////////////////
  // hit, miss and replacement
  //////////////////////////////////////////////////////////////////////

  assign anyHit    = |hitWay;
  assign miss      = rd && !anyHit;              // also high for the blocked cycle
  assign victimWay = wayMeta[0].lru;             // way 0 unless it was used last

  // lru update lands one cycle after the hit
  always_ff @(posedge clk) begin
    if (rst) begin
      pendWe <= 1'b0;
    end else begin
      pendWe <= rd && anyHit;
    end
  end

  always_ff @(posedge clk) begin
    if (rd && anyHit) begin
      pendSet <= curSet;                         // keep the set, addr moves on
      for (int w = 0; w < 2; w++) begin
        pendMeta[w] <= touch(wayMeta[w], hitWay[w], fields.tag);
      end
    end
  end

  // word to the cpu, victim way when nothing hits
  always_comb begin
    if (hitWay[0]) begin
      instr = wayData[0];
    end else if (hitWay[1]) begin
      instr = wayData[1];
    end else begin
      instr = wayData[victimWay];
    end
  end

endmodule

/* logic/fillCtrl.sv */
`timescale 1ns/1ns

module fillCtrl (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        miss,      // from the tag compare
  input  logic [icachePkg::wordW-1:0] addr,      // cpu address, held while stalled
  input  logic                        victimWay, // replacement choice
  input  logic                        memAck,    // word strobe from memory
  input  logic [icachePkg::wordW-1:0] memData,   // valid with memAck
  output logic                        memRd,     // read strobe to memory
  output logic [icachePkg::wordW-1:0] memAddr,   // word address of the read
  output logic                        dataWe,    // write one word into the victim
  output logic                        fillWay,   // latched victim
  output logic [icachePkg::offW-1:0]  fillOff,   // offset of the word written
  output logic [icachePkg::wordW-1:0] fillData,  // word written
  output logic                        metaWe     // commit strobe
);

  icachePkg::fillState         state;            // fill FSM
  icachePkg::addrFields        blockBase;        // missing block, offset zeroed
  icachePkg::addrFields        wordAddr;         // base with the counter as offset
  logic [icachePkg::offW-1:0]  wordCnt;          // next word of the block

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= icachePkg::idle;
      wordCnt <= '0;
    end else begin
      case (state)
        icachePkg::idle: begin
          if (miss) begin
            state   <= icachePkg::fetch;
            wordCnt <= '0;                       // always a full block
          end
        end
        icachePkg::fetch: begin
          if (!miss) begin
            state <= icachePkg::idle;            // only the lru-blocked cycle, no fill
          end else begin
            state <= icachePkg::waitAck;         // one request outstanding
          end
        end
        icachePkg::waitAck: begin
          if (memAck) begin
            if (&wordCnt) begin
              state <= icachePkg::commit;        // last word written
            end else begin
              state   <= icachePkg::fetch;
              wordCnt <= wordCnt + 1'b1;
            end
          end
        end
        default: begin
          state <= icachePkg::idle;              // commit lasts one cycle
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // latched block and victim
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state == icachePkg::idle && miss) begin
      blockBase     <= addr;
      blockBase.off <= '0;
      blockBase.pad <= 1'b0;
    end
    // lru is settled by the first fetch, nothing touches it until commit
    if (state == icachePkg::fetch && wordCnt == '0) begin
      fillWay <= victimWay;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory and array strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wordAddr     = blockBase;
    wordAddr.off = wordCnt;                      // walk the block in order
  end

  assign memAddr  = wordAddr;
  assign memRd    = (state == icachePkg::fetch) && miss;
  assign dataWe   = (state == icachePkg::waitAck) && memAck;
  assign fillOff  = wordCnt;
  assign fillData = memData;                     // written the cycle it arrives
  assign metaWe   = (state == icachePkg::commit);

endmodule

/* logic/icacheTop.sv */
`timescale 1ns/1ns

module icacheTop #(
  parameter int setCount = icachePkg::numSets
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd,        // cpu read level
  input  logic [icachePkg::wordW-1:0] addr,      // cpu word address
  output logic [icachePkg::wordW-1:0] instr,     // fetched word
  output logic                        stall,     // cpu must hold addr and rd
  output logic                        memRd,     // backing memory read strobe
  output logic [icachePkg::wordW-1:0] memAddr,
  input  logic                        memAck,    // word ready strobe
  input  logic [icachePkg::wordW-1:0] memData
);

  logic                        miss;
  logic                        victimWay;
  logic                        dataWe;
  logic                        fillWay;
  logic [icachePkg::offW-1:0]  fillOff;
  logic [icachePkg::wordW-1:0] fillData;
  logic                        metaWe;

  //////////////////////////////////////////////////////////////////////
  // cache ways and fill controller
  //////////////////////////////////////////////////////////////////////

  icacheWays #(
    .setCount(setCount)
  ) u_ways (
    .clk(clk), .rst(rst), .rd(rd), .addr(addr),
    .dataWe(dataWe), .fillWay(fillWay), .fillOff(fillOff), .fillData(fillData),
    .metaWe(metaWe), .instr(instr), .miss(miss), .victimWay(victimWay)
  );

  fillCtrl u_fill (
    .clk(clk), .rst(rst), .miss(miss), .addr(addr), .victimWay(victimWay),
    .memAck(memAck), .memData(memData), .memRd(memRd), .memAddr(memAddr),
    .dataWe(dataWe), .fillWay(fillWay), .fillOff(fillOff), .fillData(fillData),
    .metaWe(metaWe)
  );

  assign stall = miss;                           // any non-hit read holds the cpu

endmodule

/* bench/icacheTb.sv */
`timescale 1ns/1ns

module icacheTb;

  localparam logic [1:0] accessKind = 2'd0;         // address, word, fill flag
  localparam logic [1:0] groupKind  = 2'd1;         // start of a numbered test
  localparam logic [1:0] resetKind  = 2'd2;         // reset in the middle of the run

  // one parsed line of the trace
  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  testNum;                           // only for groupKind
    logic [15:0] addr;                              // cpu word address
    logic [15:0] word;                              // expected instr
    logic        fill;                              // 1 = full block fetched
  } traceRec;

  logic        clk = 1'b0;
  logic        rst;
  logic        rd;
  logic [15:0] addr;
  logic [15:0] instr;
  logic        stall;
  logic        memRd;
  logic [15:0] memAddr;
  logic        memAck;
  logic [15:0] memData;

  traceRec     trace [$];
  int          seed = 32'h65274387;                 // memory latency stream
  int          cycles = 0;
  int          cycleLimit = 1000;                   // replaced once the trace is read
  int          errors = 0;
  int          groupErrors = 0;
  int          checks = 0;
  int          accesses = 0;
  int          curTest = 0;

  icacheTop #(
    .setCount(icachePkg::numSets)
  ) u_icacheTop (
    .clk(clk), .rst(rst), .rd(rd), .addr(addr), .instr(instr), .stall(stall),
    .memRd(memRd), .memAddr(memAddr), .memAck(memAck), .memData(memData)
  );

  always #50 clk = ~clk;                            // 100 ns period

  //////////////////////////////////////////////////////////////////////
  // backing memory, one request at a time, 1 to 4 cycles late
  //////////////////////////////////////////////////////////////////////

  always begin
    logic [15:0] reqAddr;
    int          lat;
    @(negedge clk);
    if (memRd && !rst) begin
      reqAddr = memAddr;                            // strobe lasts one cycle
      lat = 1 + ({$random(seed)} % 4);
      repeat (lat) @(posedge clk);
      #5;
      memAck  = 1'b1;
      memData = reqAddr ^ 16'h5A3C;                 // content rule of the memory
      @(posedge clk);
      #5;
      memAck  = 1'b0;
      memData = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic string stateName(input icachePkg::fillState s);
    string name;
    case (s)
      icachePkg::idle:    name = "idle";
      icachePkg::fetch:   name = "fetch";
      icachePkg::waitAck: name = "waitAck";
      default:            name = "commit";
    endcase
    return name;
  endfunction

  task automatic countError();
    errors++;
    groupErrors++;
  endtask

  task automatic reportGroup();
    if (curTest != 0) begin
      if (groupErrors == 0) begin
        $display("group %0d: ok", curTest);
      end else begin
        $display("group %0d: %0d errors", curTest, groupErrors);
      end
    end
  endtask

  // parse the trace, skipping comments and blank lines
  task automatic loadTrace(output bit ok);
    int          fd;
    int          num;
    string       line;
    string       tok;
    logic [15:0] a;
    logic [15:0] w;
    logic [15:0] f;
    traceRec     rec;
    fd = $fopen("bench/icacheTrace.txt", "r");
    ok = (fd != 0);
    if (!ok) begin
      $display("cannot open the trace file bench/icacheTrace.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        rec = '0;
        if ($sscanf(line, "%s", tok) == 1 && tok[0] != "#") begin
          if (tok == "test") begin
            void'($sscanf(line, "%s %d", tok, num));
            rec.kind    = groupKind;
            rec.testNum = 8'(num);
          end else if (tok == "reset") begin
            rec.kind = resetKind;
          end else if ($sscanf(line, "%h %h %h", a, w, f) == 3) begin
            rec.kind = accessKind;
            rec.addr = a;
            rec.word = w;
            rec.fill = f[0];
          end else begin
            $display("the trace line '%s' has no address, word and fill flag", tok);
            ok = 1'b0;
          end
          trace.push_back(rec);
        end
      end
      $fclose(fd);
    end
  endtask

  // after any reset with rd low the cache must be quiet
  task automatic checkIdle();
    @(negedge clk);
    checks++;
    if (stall || memRd) begin
      $display("CHECK FAILED at %0t: stall %b memRd %b after reset with rd low",
               $time, stall, memRd);
      countError();
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    #5;
    rd  = 1'b0;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #5;
    rst = 1'b0;
    checkIdle();
  endtask

  // one cpu read, held until stall drops
  task automatic playAccess(input logic [15:0] a, input logic [15:0] expWord,
                            input logic expFill);
    int          reads;
    bit          done;
    logic [15:0] expAddr;
    reads = 0;
    done  = 1'b0;
    @(posedge clk);
    #5;
    rd   = 1'b1;
    addr = a;
    while (!done) begin
      @(negedge clk);                               // outputs settled here
      if (memRd) begin
        expAddr = {a[15:4], 3'(reads), 1'b0};       // block base plus word count
        checks++;
        if (memAddr != expAddr) begin
          $display("CHECK FAILED at %0t: addr %h read %0d went to %h, expected %h",
                   $time, a, reads, memAddr, expAddr);
          countError();
        end
        reads++;
      end
      done = !stall;
    end
    accesses++;
    checks += 2;
    if (instr !== expWord) begin
      $display("CHECK FAILED at %0t: addr %h gave instr %h, expected %h",
               $time, a, instr, expWord);
      countError();
    end
    if (reads != (expFill ? 8 : 0)) begin
      $display("CHECK FAILED at %0t: addr %h caused %0d memory reads, expected %0d",
               $time, a, reads, expFill ? 8 : 0);
      countError();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // run limit and main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with the fill FSM in state %s",
             cycles, stateName(u_icacheTop.u_fill.state));
    $display("test failed");
    $finish;
  end

  initial begin
    bit ok;
    int accessLines;
    int resetLines;
    rst     = 1'b1;
    rd      = 1'b0;
    addr    = '0;
    memAck  = 1'b0;
    memData = '0;
    accessLines = 0;
    resetLines  = 0;
    loadTrace(ok);
    if (!ok) begin
      $display("test failed");
      $finish;
    end else begin
      foreach (trace[i]) begin
        if (trace[i].kind == accessKind) begin
          accessLines++;
        end else if (trace[i].kind == resetKind) begin
          resetLines++;
        end
      end
      // worst case fill is 8 words of 6 cycles, plus resets and slack
      cycleLimit = accessLines * 8 * 6 + (resetLines + 1) * 8 + 100;
      repeat (8) @(posedge clk);
      #5;
      rst = 1'b0;
      checkIdle();
      foreach (trace[i]) begin
        case (trace[i].kind)
          groupKind: begin
            reportGroup();
            curTest     = int'(trace[i].testNum);
            groupErrors = 0;
          end
          resetKind: begin
            applyReset();
          end
          default: begin
            playAccess(trace[i].addr, trace[i].word, trace[i].fill);
          end
        endcase
      end
      reportGroup();
      $display("accesses %0d, checks %0d, errors %0d", accesses, checks, errors);
      if (errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

/* bench/icacheTrace.txt */
# columns: address, expected word, fill flag (hex); fill 1 = eight memory reads, 0 = none
# a line "test n" opens a numbered check group, a line "reset" pulses rst for 8 cycles
test 1
0450 5E6C 1
test 2
0452 5E6E 0
0456 5E6A 0
045A 5E66 0
045E 5E62 0
0451 5E6C 0
test 3
0850 526C 1
0450 5E6C 0
0856 526A 0
045A 5E66 0
0850 526C 0
test 4
0C50 566C 1
0852 526E 0
0454 5E68 1
0850 526C 0
0C5E 5662 1
test 5
FFF0 A5CC 1
FFFE A5C2 0
0000 5A3C 1
000E 5A32 0
56A0 0C9C 1
56A6 0C9A 0
0C50 566C 0
test 6
reset
0850 526C 1
0000 5A3C 1
0002 5A3E 0

/* vlog.f */
logic/icachePkg.sv
logic/dataArray.sv
logic/metaArray.sv
logic/icacheWays.sv
logic/fillCtrl.sv
logic/icacheTop.sv
bench/icacheTb.sv

/* Makefile */
SIM := obj_dir/VicacheTb

.PHONY: all run clean

all: run

$(SIM): vlog.f $(wildcard logic/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --timescale 1ns/1ns --top-module icacheTb -f vlog.f -o VicacheTb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
